/* rtl/coin_inputs.sv */
`timescale 1ns/10ps
`default_nettype none
`include "vend_config.svh"

module coin_inputs import vend_pkg::*; (
    input  wire      clk,
    input  wire      rst,
    input  wire      btn_5,
    input  wire      btn_10,
    input  wire      btn_50,
    input  wire      btn_cancel,
    output vm_coin_t coin
);

    localparam int deb_len = `VM_DEBOUNCE_LEN;

    logic [3:0]         btn;
    logic [deb_len-1:0] shift_q [4];
    logic [3:0]         stable;
    logic [3:0]         stable_q;
    logic [3:0]         pulse_q;

    // bit order follows priority, cancel on top
    assign btn = {btn_cancel, btn_50, btn_10, btn_5};

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            stable[i] = &shift_q[i];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 4; i++) begin
                shift_q[i] <= '0;
            end
            stable_q <= '0;
            pulse_q  <= '0;
        end else begin
            for (int i = 0; i < 4; i++) begin
                shift_q[i] <= deb_len'({shift_q[i], btn[i]}); // oldest sample drops out
            end
            stable_q <= stable;
            pulse_q  <= stable & ~stable_q; // rising edge of debounced level
        end
    end

    // keep only the strongest event
    always_comb begin
        coin = '0;
        if (pulse_q[3]) begin
            coin.cancel = 1'b1;
        end else if (pulse_q[2]) begin
            coin.add_50 = 1'b1;
        end else if (pulse_q[1]) begin
            coin.add_10 = 1'b1;
        end else if (pulse_q[0]) begin
            coin.add_5 = 1'b1;
        end
    end

endmodule

`default_nettype wire

/* rtl/scan_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module scan_decoder import vend_pkg::*; (
    input  wire       clk,
    input  wire       rst,
    input  wire [7:0] ps2_byte,
    input  wire       ps2_valid,
    input  wire       sel_ready,
    output logic      ps2_ready,
    output logic      sel_valid,
    output vm_sel_t   sel
);

    localparam logic [7:0] code_a   = 8'h1c;
    localparam logic [7:0] code_s   = 8'h1b;
    localparam logic [7:0] code_d   = 8'h23;
    localparam logic [7:0] code_f   = 8'h2b;
    localparam logic [7:0] code_ext = 8'he0;
    localparam logic [7:0] code_brk = 8'hf0;

    logic       ext_q;
    logic       brk_q;
    logic [3:0] held_q;
    logic       xfer;
    logic       key_hit;
    vm_item_t   key_item;
    logic       new_sel;
    logic       key_up;

    // stall the byte stream while a selection waits
    assign ps2_ready = ~sel_valid;
    assign xfer      = ps2_valid & ps2_ready;

    always_comb begin
        key_hit  = 1'b1;
        key_item = item_f;
        case (ps2_byte)
            code_a:  key_item = item_a;
            code_s:  key_item = item_s;
            code_d:  key_item = item_d;
            code_f:  key_item = item_f;
            default: key_hit = 1'b0; // includes E0 and F0
        endcase
    end

    // extended codes are never items
    assign new_sel = xfer & key_hit & ~ext_q & ~brk_q & ~held_q[key_item];
    assign key_up  = xfer & key_hit & ~ext_q & brk_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ext_q     <= 1'b0;
            brk_q     <= 1'b0;
            held_q    <= '0;
            sel_valid <= 1'b0;
        end else begin
            if (xfer) begin
                if (ps2_byte == code_ext) begin
                    ext_q <= 1'b1;
                end else if (ps2_byte == code_brk) begin
                    brk_q <= 1'b1;
                end else begin
                    ext_q <= 1'b0; // final byte of a sequence
                    brk_q <= 1'b0;
                end
            end
            if (new_sel) begin
                held_q[key_item] <= 1'b1; // typematic repeats now ignored
            end else if (key_up) begin
                held_q[key_item] <= 1'b0;
            end
            if (sel_valid && sel_ready) begin
                sel_valid <= 1'b0;
            end else if (new_sel) begin
                sel_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (new_sel) begin
            sel.item <= key_item;
        end
    end

    sel_stable_a: assert property (@(posedge clk) disable iff (rst)
        sel_valid && !sel_ready |=> sel_valid && $stable(sel));

endmodule

`default_nettype wire

/* rtl/segment_display.sv */
`timescale 1ns/10ps
`default_nettype none
`include "vend_config.svh"

module segment_display import vend_pkg::*; (
    input  wire             clk,
    input  wire             rst,
    input  wire vm_credit_t credit,
    output logic [6:0]      seg,
    output logic [3:0]      digit_sel
);

    localparam logic [3:0] blank = 4'hf;

    logic [`VM_SCAN_BITS-1:0] scan_q;
    logic [1:0]               digit_idx;
    logic [3:0]               h_raw;
    logic [3:0]               t_raw;
    logic [3:0]               hundreds;
    logic [3:0]               tens;
    logic [3:0]               ones;
    logic [3:0]               cur;

    // active low, bit order gfedcba
    function automatic logic [6:0] seg_of(input logic [3:0] d);
        case (d)
            4'd0:    seg_of = 7'b1000000;
            4'd1:    seg_of = 7'b1111001;
            4'd2:    seg_of = 7'b0100100;
            4'd3:    seg_of = 7'b0110000;
            4'd4:    seg_of = 7'b0011001;
            4'd5:    seg_of = 7'b0010010;
            4'd6:    seg_of = 7'b0000010;
            4'd7:    seg_of = 7'b1111000;
            4'd8:    seg_of = 7'b0000000;
            4'd9:    seg_of = 7'b0010000;
            default: seg_of = 7'b1111111;
        endcase
    endfunction

    always_comb begin
        h_raw    = 4'(credit / 8'd100);
        t_raw    = 4'((credit % 8'd100) / 8'd10);
        ones     = 4'(credit % 8'd10); // always shown, so 0 reads as 0
        hundreds = (h_raw == 4'd0) ? blank : h_raw;
        tens     = (h_raw == 4'd0 && t_raw == 4'd0) ? blank : t_raw;
    end

    assign digit_idx = scan_q[`VM_SCAN_BITS-1 -: 2];

    always_comb begin
        case (digit_idx)
            2'd0:    cur = ones;
            2'd1:    cur = tens;
            2'd2:    cur = hundreds;
            default: cur = blank; // fourth digit unused
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scan_q    <= '0;
            digit_sel <= 4'b1111;
            seg       <= 7'b1111111;
        end else begin
            scan_q    <= scan_q + 1'b1;
            digit_sel <= ~(4'b0001 << digit_idx);
            seg       <= seg_of(cur);
        end
    end

endmodule

`default_nettype wire

/* rtl/vend_config.svh */
`ifndef VEND_CONFIG_SVH
`define VEND_CONFIG_SVH

// item prices in credit units
`define VM_PRICE_F 20
`define VM_PRICE_D 25
`define VM_PRICE_S 30
`define VM_PRICE_A 80

// credit saturates here
`define VM_CREDIT_MAX 100

// one returned coin
`define VM_COIN_UNIT 5

// cycles between returned coins
`define VM_TICK_CYCLES 16

// stable samples before a press counts
`define VM_DEBOUNCE_LEN 4

// digit scan counter width, top two bits pick the digit
`define VM_SCAN_BITS 2

`endif

/* rtl/vend_controller.sv */
`timescale 1ns/10ps
`default_nettype none
`include "vend_config.svh"

module vend_controller import vend_pkg::*; (
    input  wire           clk,
    input  wire           rst,
    input  wire vm_coin_t coin,
    input  wire           sel_valid,
    input  wire vm_sel_t  sel,
    output logic          sel_ready,
    output logic          vend_valid,
    output vm_item_t      vend_item,
    output logic          coin_return,
    output vm_credit_t    credit,
    output logic [3:0]    item_led
);

    localparam int                tick_w     = $clog2(`VM_TICK_CYCLES + 1);
    localparam logic [tick_w-1:0] tick_last  = tick_w'(`VM_TICK_CYCLES - 1);
    localparam vm_credit_t        credit_max = vm_credit_t'(`VM_CREDIT_MAX);
    localparam vm_credit_t        coin_unit  = vm_credit_t'(`VM_COIN_UNIT);

    logic              refund_q;
    logic [tick_w-1:0] tick_q;
    vm_credit_t        price;
    vm_credit_t        coin_amt;
    logic [8:0]        sum;
    vm_credit_t        credit_add;
    logic              has_coin;
    logic              buy;

    function automatic vm_credit_t price_of(input vm_item_t item);
        case (item)
            item_a:  price_of = vm_credit_t'(`VM_PRICE_A);
            item_s:  price_of = vm_credit_t'(`VM_PRICE_S);
            item_d:  price_of = vm_credit_t'(`VM_PRICE_D);
            default: price_of = vm_credit_t'(`VM_PRICE_F);
        endcase
    endfunction

    assign has_coin = |coin;
    // coin events win over a selection in the same cycle
    assign sel_ready = ~refund_q & ~has_coin;
    assign price     = price_of(sel.item);
    assign buy       = sel_valid & sel_ready & (credit >= price);

    always_comb begin
        if (coin.add_50) begin
            coin_amt = 8'd50;
        end else if (coin.add_10) begin
            coin_amt = 8'd10;
        end else if (coin.add_5) begin
            coin_amt = coin_unit;
        end else begin
            coin_amt = '0;
        end
        sum        = {1'b0, credit} + {1'b0, coin_amt};
        credit_add = (sum > {1'b0, credit_max}) ? credit_max : sum[7:0]; // saturate
    end

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            item_led[i] = ~refund_q & (credit >= price_of(vm_item_t'(i)));
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            refund_q    <= 1'b0;
            tick_q      <= '0;
            credit      <= '0;
            vend_valid  <= 1'b0;
            coin_return <= 1'b0;
        end else begin
            vend_valid  <= 1'b0;
            coin_return <= 1'b0;
            if (!refund_q) begin
                tick_q <= '0;
                if (coin.cancel) begin
                    refund_q <= (credit != '0); // nothing to return at zero
                end else if (has_coin) begin
                    credit <= credit_add;
                end else if (buy) begin
                    credit     <= credit - price;
                    vend_valid <= 1'b1;
                    refund_q   <= (credit != price);
                end
            end else if (credit == '0) begin
                refund_q <= 1'b0;
            end else if (tick_q == tick_last) begin
                tick_q      <= '0;
                credit      <= credit - coin_unit;
                coin_return <= 1'b1;
            end else begin
                tick_q <= tick_q + tick_w'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (buy) begin
            vend_item <= sel.item;
        end
    end

    credit_max_a: assert property (@(posedge clk) disable iff (rst)
        credit <= credit_max);

    return_in_refund_a: assert property (@(posedge clk) disable iff (rst)
        coin_return |-> refund_q);

endmodule

`default_nettype wire

/* rtl/vend_pkg.sv */
`default_nettype none

package vend_pkg;

    // item codes, also the item_led bit index
    typedef enum logic [1:0] {
        item_f = 2'd0,
        item_d = 2'd1,
        item_s = 2'd2,
        item_a = 2'd3
    } vm_item_t;

    // one-cycle coin event, at most one field set
    typedef struct packed {
        logic cancel;
        logic add_50;
        logic add_10;
        logic add_5;
    } vm_coin_t;

    // keyboard selection
    typedef struct packed {
        vm_item_t item;
    } vm_sel_t;

    // multiple of 5, never above 100
    typedef logic [7:0] vm_credit_t;

endpackage

`default_nettype wire

/* rtl/vending_machine.sv */
`timescale 1ns/10ps
`default_nettype none

module vending_machine import vend_pkg::*; (
    input  wire        clk,
    input  wire        rst,
    input  wire        btn_5,
    input  wire        btn_10,
    input  wire        btn_50,
    input  wire        btn_cancel,
    input  wire [7:0]  ps2_byte,
    input  wire        ps2_valid,
    output logic       ps2_ready,
    output vm_credit_t credit,
    output logic [3:0] item_led,
    output logic       vend_valid,
    output vm_item_t   vend_item,
    output logic       coin_return,
    output logic [6:0] seg,
    output logic [3:0] digit_sel
);

    vm_coin_t coin;
    vm_sel_t  sel;
    logic     sel_valid;
    logic     sel_ready;

    coin_inputs coin_inputs_i (
        .clk        (clk),
        .rst        (rst),
        .btn_5      (btn_5),
        .btn_10     (btn_10),
        .btn_50     (btn_50),
        .btn_cancel (btn_cancel),
        .coin       (coin)
    );

    scan_decoder scan_decoder_i (
        .clk       (clk),
        .rst       (rst),
        .ps2_byte  (ps2_byte),
        .ps2_valid (ps2_valid),
        .sel_ready (sel_ready),
        .ps2_ready (ps2_ready),
        .sel_valid (sel_valid),
        .sel       (sel)
    );

    vend_controller vend_controller_i (
        .clk         (clk),
        .rst         (rst),
        .coin        (coin),
        .sel_valid   (sel_valid),
        .sel         (sel),
        .sel_ready   (sel_ready),
        .vend_valid  (vend_valid),
        .vend_item   (vend_item),
        .coin_return (coin_return),
        .credit      (credit),
        .item_led    (item_led)
    );

    segment_display segment_display_i (
        .clk       (clk),
        .rst       (rst),
        .credit    (credit),
        .seg       (seg),
        .digit_sel (digit_sel)
    );

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Build and run the vending machine testbench with Verilator.
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f vlog.f \
    --top-module vending_machine_tb -o vending_machine_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/vending_machine_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "=== FAIL ===" sim.log; then
    exit 1
fi
exit 0

/* testbench/vending_machine_tb.sv */
`timescale 1ns/10ps
`default_nettype none
`include "vend_config.svh"

module vending_machine_tb import vend_pkg::*; ();

    typedef struct packed {
        logic [7:0] credit;
        logic [3:0] leds;
        logic       vend;
        logic [7:0] returns;
    } outcome_t;

    localparam int op_coin        = 0;
    localparam int op_cancel      = 1;
    localparam int op_select      = 2;
    localparam int op_none        = 3;
    localparam int num_rand       = 24;
    localparam int num_ops        = 30 + 2 * num_rand; // fixed ops, then up to two per draw
    localparam int press_len      = `VM_DEBOUNCE_LEN + 3;
    localparam int timeout_cycles = num_ops * (20 * `VM_TICK_CYCLES + 64);

    logic        clk;
    logic        rst;
    logic        btn_5;
    logic        btn_10;
    logic        btn_50;
    logic        btn_cancel;
    logic [7:0]  ps2_byte;
    logic        ps2_valid;
    logic        ps2_ready;
    vm_credit_t  credit;
    logic [3:0]  item_led;
    logic        vend_valid;
    vm_item_t    vend_item;
    vm_item_t    exp_item;
    logic        coin_return;
    logic [6:0]  seg;
    logic [3:0]  digit_sel;
    logic [31:0] lfsr_state = 32'hdd7b_a48f;
    int          cycles     = 0;
    int          vend_cnt   = 0;
    int          ret_cnt    = 0;
    int          mon_errors = 0;
    int          chk_errors = 0;
    int          exp_credit = 0;

    vending_machine vending_machine_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // taps 32 22 2 1, shifting right
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic int rand_bits(input int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            r = (r << 1) | int'(lfsr_state[0]);
        end
        return r;
    endfunction

    function automatic int item_price(input int item);
        case (item)
            0:       return `VM_PRICE_F;
            1:       return `VM_PRICE_D;
            2:       return `VM_PRICE_S;
            default: return `VM_PRICE_A;
        endcase
    endfunction

    function automatic logic [7:0] key_code(input int item);
        case (item)
            0:       return 8'h2b;
            1:       return 8'h23;
            2:       return 8'h1b;
            default: return 8'h1c;
        endcase
    endfunction

    // active low, gfedcba
    function automatic logic [6:0] seg_pattern(input int d);
        case (d)
            0:       return 7'h40;
            1:       return 7'h79;
            2:       return 7'h24;
            3:       return 7'h30;
            4:       return 7'h19;
            5:       return 7'h12;
            6:       return 7'h02;
            7:       return 7'h78;
            8:       return 7'h00;
            9:       return 7'h10;
            default: return 7'h7f;
        endcase
    endfunction

    // expected result of one operation started from idle
    function automatic outcome_t predict(input int credit_now, input int op, input int arg);
        outcome_t o;
        int       c;
        o = '0;
        c = credit_now;
        case (op)
            op_coin: begin
                c = c + ((arg == 0) ? 5 : (arg == 1) ? 10 : 50);
                if (c > `VM_CREDIT_MAX) c = `VM_CREDIT_MAX; // saturate
            end
            op_cancel: begin
                o.returns = 8'(c / `VM_COIN_UNIT);
                c = 0;
            end
            op_select: begin
                if (c >= item_price(arg)) begin
                    o.vend    = 1'b1;
                    o.returns = 8'((c - item_price(arg)) / `VM_COIN_UNIT);
                    c = 0;
                end
            end
            default: ;
        endcase
        o.credit = 8'(c);
        for (int i = 0; i < 4; i++) o.leds[i] = (c >= item_price(i));
        return o;
    endfunction

    // pulse counting, vend item check and timeout
    always @(negedge clk) begin
        cycles = cycles + 1;
        if (cycles > timeout_cycles) begin
            $display("timeout after %0d cycles, the DUT stopped responding", cycles);
            $display("=== FAIL ===");
            $finish;
        end else if (!rst) begin
            if (vend_valid) begin
                vend_cnt = vend_cnt + 1;
                if (vend_item != exp_item) begin
                    $display("mismatch at %0t: vend_item is %0d, expected %0d",
                             $time, vend_item, exp_item);
                    mon_errors = mon_errors + 1;
                end
            end
            if (coin_return) ret_cnt = ret_cnt + 1;
        end
    end

    task automatic report_mismatch(input string what, input int got, input int want);
        $display("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, want);
        chk_errors = chk_errors + 1;
    endtask

    task automatic report_problem(input string what);
        $display("at %0t: %s", $time, what);
        chk_errors = chk_errors + 1;
    endtask

    task automatic press(input int kind, input int hold);
        @(posedge clk);
        case (kind)
            0:       btn_5 <= 1'b1;
            1:       btn_10 <= 1'b1;
            2:       btn_50 <= 1'b1;
            default: btn_cancel <= 1'b1;
        endcase
        repeat (hold) @(posedge clk);
        btn_5      <= 1'b0;
        btn_10     <= 1'b0;
        btn_50     <= 1'b0;
        btn_cancel <= 1'b0;
        repeat (press_len) @(posedge clk);
    endtask

    task automatic send_byte(input logic [7:0] b);
        logic taken;
        @(posedge clk);
        ps2_byte  <= b;
        ps2_valid <= 1'b1;
        do begin
            @(negedge clk);
            taken = ps2_ready; // ready only moves on the rising edge
            @(posedge clk);
        end while (!taken);
        ps2_valid <= 1'b0;
    endtask

    // wait for idle with the predicted totals, then one more tick period for stray pulses
    task automatic settle(input outcome_t o, input int vbase, input int rbase);
        do begin
            @(negedge clk);
        end while (!(ps2_ready && credit == o.credit && vend_cnt == vbase + int'(o.vend)
                     && ret_cnt == rbase + int'(o.returns)));
        repeat (`VM_TICK_CYCLES + 2) @(negedge clk);
        if (credit != o.credit) report_mismatch("credit", int'(credit), int'(o.credit));
        if (item_led != o.leds) report_mismatch("item_led", int'(item_led), int'(o.leds));
        if (vend_cnt != vbase + int'(o.vend))
            report_mismatch("vend count", vend_cnt - vbase, int'(o.vend));
        if (ret_cnt != rbase + int'(o.returns))
            report_mismatch("coin returns", ret_cnt - rbase, int'(o.returns));
        exp_credit = int'(o.credit);
    endtask

    task automatic run_op(input int op, input int arg, input logic [7:0] code);
        outcome_t o;
        int       vbase;
        int       rbase;
        o        = predict(exp_credit, op, arg);
        vbase    = vend_cnt;
        rbase    = ret_cnt;
        exp_item = vm_item_t'(arg[1:0]);
        if (op == op_coin) press(arg, press_len);
        else if (op == op_cancel) press(3, press_len);
        else send_byte(code);
        settle(o, vbase, rbase);
    endtask

    task automatic check_display();
        int idx;
        int d;
        repeat (8) begin
            @(negedge clk);
            idx = 4;
            for (int i = 0; i < 4; i++) if (digit_sel == ~(4'b0001 << i)) idx = i;
            case (idx)
                0:       d = exp_credit % 10;
                1:       d = (exp_credit >= 10) ? (exp_credit / 10) % 10 : 15;
                2:       d = (exp_credit >= 100) ? exp_credit / 100 : 15;
                default: d = 15; // blank
            endcase
            if (idx == 4) report_problem("digit_sel does not enable exactly one digit");
            else if (seg != seg_pattern(d)) report_mismatch("seg", int'(seg), int'(seg_pattern(d)));
        end
    endtask

    initial begin
        outcome_t o;
        int       vbase;
        int       rbase;
        int       r;
        int       item;
        rst        = 1'b1;
        btn_5      = 1'b0;
        btn_10     = 1'b0;
        btn_50     = 1'b0;
        btn_cancel = 1'b0;
        ps2_byte   = 8'h00;
        ps2_valid  = 1'b0;
        exp_item   = item_f;
        repeat (3) @(posedge clk);
        @(negedge clk);
        if (vend_valid || coin_return || !ps2_ready || credit != 8'd0 || item_led != 4'd0
            || digit_sel != 4'hf)
            report_problem("outputs are not at their reset values");
        @(posedge clk);
        rst <= 1'b0;
        @(posedge clk); // first digit enable lands on this edge
        check_display();
        run_op(op_coin, 0, 8'h00);
        check_display();
        o     = predict(exp_credit, op_coin, 1); // a long press still counts once
        vbase = vend_cnt;
        rbase = ret_cnt;
        press(1, 40);
        settle(o, vbase, rbase);
        run_op(op_coin, 2, 8'h00);
        run_op(op_coin, 2, 8'h00);
        check_display();
        run_op(op_coin, 1, 8'h00);
        // vend A from 100, then queue S while the change is paid out
        o        = predict(exp_credit, op_select, 3);
        vbase    = vend_cnt;
        rbase    = ret_cnt;
        exp_item = item_a;
        send_byte(8'h1c);
        send_byte(8'h1b);
        @(negedge clk);
        if (ps2_ready) report_problem("ps2_ready is high while a selection waits in refund");
        send_byte(8'hf0);
        if (ret_cnt != rbase + int'(o.returns))
            report_problem("a keyboard byte was taken before the refund finished");
        send_byte(8'h1c);
        send_byte(8'hf0);
        send_byte(8'h1b);
        settle(o, vbase, rbase);
        // cancel with a coin pushed during the refund
        run_op(op_coin, 2, 8'h00);
        run_op(op_coin, 1, 8'h00);
        o     = predict(exp_credit, op_cancel, 0);
        vbase = vend_cnt;
        rbase = ret_cnt;
        press(3, press_len);
        press(1, press_len);
        settle(o, vbase, rbase);
        run_op(op_cancel, 0, 8'h00);
        run_op(op_coin, 1, 8'h00);
        run_op(op_select, 0, 8'h2b); // too little credit
        send_byte(8'hf0);
        run_op(op_none, 0, 8'h2b);
        run_op(op_coin, 1, 8'h00);
        send_byte(8'hf0);
        run_op(op_none, 0, 8'h2b);
        send_byte(8'he0);
        run_op(op_none, 0, 8'h2b);
        send_byte(8'he0);
        send_byte(8'hf0);
        run_op(op_none, 0, 8'h2b);
        run_op(op_none, 0, 8'h15);
        run_op(op_select, 0, 8'h2b);
        run_op(op_coin, 1, 8'h00);
        run_op(op_coin, 1, 8'h00);
        run_op(op_none, 0, 8'h2b); // still held, typematic repeat
        send_byte(8'hf0);
        run_op(op_none, 0, 8'h2b);
        run_op(op_select, 0, 8'h2b);
        send_byte(8'hf0);
        run_op(op_none, 0, 8'h2b);
        run_op(op_coin, 1, 8'h00);
        run_op(op_coin, 1, 8'h00);
        run_op(op_coin, 1, 8'h00);
        run_op(op_select, 2, 8'h1b); // S was released during the earlier stall
        send_byte(8'hf0);
        run_op(op_none, 0, 8'h1b);
        for (int n = 0; n < num_rand; n++) begin
            r = rand_bits(3);
            if (r <= 3) begin
                run_op(op_coin, (r == 3) ? 2 : r, 8'h00);
            end else if (r == 4) begin
                run_op(op_cancel, 0, 8'h00);
            end else begin
                item = rand_bits(2);
                run_op(op_select, item, key_code(item));
                send_byte(8'hf0);
                run_op(op_none, 0, key_code(item));
            end
            check_display();
        end
        $display("errors: %0d in checks, %0d in the monitor", chk_errors, mon_errors);
        if (chk_errors + mon_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+rtl
rtl/vend_pkg.sv
rtl/coin_inputs.sv
rtl/scan_decoder.sv
rtl/vend_controller.sv
rtl/segment_display.sv
rtl/vending_machine.sv
testbench/vending_machine_tb.sv
